//--- hw/blimp_params.svh
//--------------------
// Blimp core parameters
// Widths and depths shared by the core and its testbench
//--------------------

`ifndef BLIMP_PARAMS_SVH
`define BLIMP_PARAMS_SVH

// Data and address width
`define BLIMP_XLEN 32

// Sequence number width, 2**bits instructions in flight
`define BLIMP_SEQ_BITS 3

// Width of the memory opaque tag
`define BLIMP_OPAQ_BITS 4

// Multiplier pipeline depth, 2 or more
`define BLIMP_MUL_STAGES 4

`endif

//--- hw/blimp_pkg.sv
//--------------------
// Blimp core types
// Decoded opcodes and the packed bundles passed between units
//--------------------

`include "blimp_params.svh"

package blimp_pkg;

  // Decoded operation, anything unknown becomes a nop
  typedef enum logic [2:0] {
    OP_NOP,
    OP_ADD,
    OP_ADDI,
    OP_MUL,
    OP_LUI
  } op_e;

  //--------------------
  // Instruction memory
  //--------------------

  typedef struct packed {
    logic [`BLIMP_XLEN-1:0]      addr;
    logic [`BLIMP_OPAQ_BITS-1:0] opaque;
  } mem_req_t;

  typedef struct packed {
    logic [`BLIMP_XLEN-1:0]      data;
    logic [`BLIMP_OPAQ_BITS-1:0] opaque;
  } mem_resp_t;

  //--------------------
  // Pipeline
  //--------------------

  // Fetch to decode
  typedef struct packed {
    logic [`BLIMP_XLEN-1:0]     pc;
    logic [`BLIMP_XLEN-1:0]     inst;
    logic [`BLIMP_SEQ_BITS-1:0] seq;
  } f_d_t;

  // Decode to execute
  typedef struct packed {
    op_e                        op;
    logic [`BLIMP_XLEN-1:0]     op1;
    logic [`BLIMP_XLEN-1:0]     op2;
    logic [4:0]                 waddr;
    logic                       wen;
    logic [`BLIMP_XLEN-1:0]     pc;
    logic [`BLIMP_SEQ_BITS-1:0] seq;
  } d_x_t;

  // Execute to writeback
  typedef struct packed {
    logic [`BLIMP_XLEN-1:0]     pc;
    logic [`BLIMP_SEQ_BITS-1:0] seq;
    logic [4:0]                 waddr;
    logic                       wen;
    logic [`BLIMP_XLEN-1:0]     data;
  } x_w_t;

  //--------------------
  // Notifications
  //--------------------

  // Writeback to register file and scoreboard
  typedef struct packed {
    logic [4:0]             waddr;
    logic [`BLIMP_XLEN-1:0] wdata;
    logic                   wen;
    logic                   val;
  } complete_t;

  // In-order commit, also the trace record
  typedef struct packed {
    logic [`BLIMP_XLEN-1:0] pc;
    logic [4:0]             waddr;
    logic [`BLIMP_XLEN-1:0] wdata;
    logic                   wen;
    logic                   val;
  } commit_t;

endpackage

//--- hw/fetch_unit.sv
//--------------------
// Fetch unit
// Sequential pc, one request outstanding, seq numbers freed by commit
//--------------------

`include "blimp_params.svh"

module fetch_unit import blimp_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  output logic      mem_req_val,
  output mem_req_t  mem_req,
  input  logic      mem_req_rdy,
  input  logic      mem_resp_val,
  input  mem_resp_t mem_resp,
  output logic      mem_resp_rdy,
  output logic      f_d_val,
  output f_d_t      f_d,
  input  logic      f_d_rdy,
  input  commit_t   commit
);

  localparam logic [`BLIMP_SEQ_BITS:0] SEQ_CAP = 1 << `BLIMP_SEQ_BITS;

  logic [`BLIMP_XLEN-1:0]      pc_q;
  logic [`BLIMP_SEQ_BITS-1:0]  seq_q;
  logic [`BLIMP_SEQ_BITS:0]    inflight_q;
  logic [`BLIMP_OPAQ_BITS-1:0] opaq_q;
  logic                        req_out_q;
  logic                        f_d_val_q;
  logic                        buf_free;
  logic                        req_fire;
  logic                        resp_fire;
  logic                        f_d_fire;

  // Output buffer empty now or drained this cycle
  assign f_d_fire = f_d_val_q && f_d_rdy;
  assign buf_free = !f_d_val_q || f_d_rdy;

  // Request only when nothing is outstanding, a seq number is free and memory can take it
  assign mem_req_val = !req_out_q && buf_free && (inflight_q < SEQ_CAP) && mem_req_rdy;
  assign mem_req     = '{addr: pc_q, opaque: opaq_q};
  assign req_fire    = mem_req_val && mem_req_rdy;

  // Responses with a stale tag are dropped
  assign mem_resp_rdy = 1'b1;
  assign resp_fire    = mem_resp_val && req_out_q && (mem_resp.opaque == opaq_q);

  assign f_d_val = f_d_val_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_q       <= '0;
      seq_q      <= '0;
      inflight_q <= '0;
      opaq_q     <= '0;
      req_out_q  <= 1'b0;
      f_d_val_q  <= 1'b0;
    end else begin
      if (req_fire) begin
        req_out_q <= 1'b1;
      end else if (resp_fire) begin
        req_out_q <= 1'b0;
      end
      // Next pc, seq and tag once the word is in
      if (resp_fire) begin
        pc_q   <= pc_q + `BLIMP_XLEN'(4);
        seq_q  <= seq_q + 1'b1;
        opaq_q <= opaq_q + 1'b1;
      end
      if (resp_fire) begin
        f_d_val_q <= 1'b1;
      end else if (f_d_fire) begin
        f_d_val_q <= 1'b0;
      end
      // Allocate on request, free on commit
      case ({req_fire, commit.val})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  // Held until decode takes it
  always_ff @(posedge clk) begin
    if (resp_fire) begin
      f_d <= '{pc: pc_q, inst: mem_resp.data, seq: seq_q};
    end
  end

endmodule

//--- hw/decode_issue_unit.sv
//--------------------
// Decode and issue unit
// Register file, scoreboard and steering to the ALU or multiplier
//--------------------

`include "blimp_params.svh"

module decode_issue_unit import blimp_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      f_d_val,
  input  f_d_t      f_d,
  output logic      f_d_rdy,
  output logic      alu_val,
  output d_x_t      alu_op,
  output logic      mul_val,
  output d_x_t      mul_op,
  input  complete_t complete
);

  localparam int unsigned OCC_W = `BLIMP_MUL_STAGES - 1;

  logic [`BLIMP_XLEN-1:0] regfile [32];
  logic [31:0]            pending_q;
  logic [OCC_W-1:0]       mul_occ_q;

  logic [6:0]             opcode;
  logic [4:0]             rd;
  logic [2:0]             funct3;
  logic [4:0]             rs1;
  logic [4:0]             rs2;
  logic [6:0]             funct7;
  op_e                    op;
  logic                   uses_rs1;
  logic                   uses_rs2;
  logic                   wen;
  logic [`BLIMP_XLEN-1:0] rs1_data;
  logic [`BLIMP_XLEN-1:0] rs2_data;
  logic [`BLIMP_XLEN-1:0] imm_i;
  logic [`BLIMP_XLEN-1:0] imm_u;
  logic [`BLIMP_XLEN-1:0] op2;
  logic                   hazard;
  logic                   alu_block;
  logic                   issue;
  d_x_t                   issue_op;
  logic [31:0]            set_mask;
  logic [31:0]            clr_mask;

  //--------------------
  // Decode
  //--------------------

  assign opcode = f_d.inst[6:0];
  assign rd     = f_d.inst[11:7];
  assign funct3 = f_d.inst[14:12];
  assign rs1    = f_d.inst[19:15];
  assign rs2    = f_d.inst[24:20];
  assign funct7 = f_d.inst[31:25];

  always_comb begin
    op = OP_NOP;
    case (opcode)
      // R-type, add or mul by funct7
      7'b0110011: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
          op = OP_ADD;
        end else if (funct3 == 3'b000 && funct7 == 7'b0000001) begin
          op = OP_MUL;
        end
      end
      7'b0010011: begin
        if (funct3 == 3'b000) begin
          op = OP_ADDI;
        end
      end
      7'b0110111: op = OP_LUI;
      default:    op = OP_NOP;
    endcase
  end

  assign uses_rs1 = (op == OP_ADD) || (op == OP_ADDI) || (op == OP_MUL);
  assign uses_rs2 = (op == OP_ADD) || (op == OP_MUL);
  // No write for nops or x0
  assign wen      = (op != OP_NOP) && (rd != 5'd0);

  // Register read, x0 hardwired
  assign rs1_data = (rs1 == 5'd0) ? '0 : regfile[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regfile[rs2];

  // I-type sign extended, U-type left unshifted for the ALU
  assign imm_i = {{(`BLIMP_XLEN-12){f_d.inst[31]}}, f_d.inst[31:20]};
  assign imm_u = {{(`BLIMP_XLEN-20){1'b0}}, f_d.inst[31:12]};

  always_comb begin
    case (op)
      OP_ADDI: op2 = imm_i;
      OP_LUI:  op2 = imm_u;
      default: op2 = rs2_data;
    endcase
  end

  //--------------------
  // Issue
  //--------------------

  // Completing registers still pending this cycle
  assign hazard = (uses_rs1 && pending_q[rs1]) ||
                  (uses_rs2 && pending_q[rs2]) ||
                  (wen && pending_q[rd]);

  // ALU result would land with a multiplier result
  assign alu_block = (op != OP_MUL) && mul_occ_q[OCC_W-1];

  assign f_d_rdy = !hazard && !alu_block;
  assign issue   = f_d_val && f_d_rdy;

  assign issue_op = '{op: op, op1: rs1_data, op2: op2, waddr: rd, wen: wen,
                      pc: f_d.pc, seq: f_d.seq};

  // Nops ride the ALU so they still reach the reorder buffer
  assign alu_val = issue && (op != OP_MUL);
  assign mul_val = issue && (op == OP_MUL);
  assign alu_op  = issue_op;
  assign mul_op  = issue_op;

  //--------------------
  // State
  //--------------------

  always_ff @(posedge clk) begin
    if (complete.val && complete.wen) begin
      regfile[complete.waddr] <= complete.wdata;
    end
  end

  assign set_mask = (issue && wen) ? (32'd1 << rd) : '0;
  assign clr_mask = (complete.val && complete.wen) ? (32'd1 << complete.waddr) : '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pending_q <= '0;
      mul_occ_q <= '0;
    end else begin
      pending_q <= (pending_q & ~clr_mask) | set_mask;
      // Bit i set when a mul issued i+1 cycles ago
      mul_occ_q <= (mul_occ_q << 1) | OCC_W'(mul_val);
    end
  end

endmodule

//--- hw/alu_unit.sv
//--------------------
// ALU pipe
// One-cycle add, addi and lui with a registered result
//--------------------

`include "blimp_params.svh"

module alu_unit import blimp_pkg::*; (
  input  logic clk,
  input  logic arst_n,
  input  logic alu_val,
  input  d_x_t alu_op,
  output logic alu_res_val,
  output x_w_t alu_res
);

  logic [`BLIMP_XLEN-1:0] result;

  always_comb begin
    case (alu_op.op)
      // Immediate already sits in op2 for addi
      OP_ADD, OP_ADDI: result = alu_op.op1 + alu_op.op2;
      OP_LUI:          result = alu_op.op2 << 12;
      default:         result = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      alu_res_val <= 1'b0;
    end else begin
      alu_res_val <= alu_val;
    end
  end

  // Tag fields travel with the result
  always_ff @(posedge clk) begin
    if (alu_val) begin
      alu_res <= '{pc: alu_op.pc, seq: alu_op.seq, waddr: alu_op.waddr,
                   wen: alu_op.wen, data: result};
    end
  end

endmodule

//--- hw/pipelined_multiplier.sv
//--------------------
// Multiplier pipe
// Fixed-depth pipeline, one new operation per cycle
//--------------------

`include "blimp_params.svh"

module pipelined_multiplier import blimp_pkg::*; (
  input  logic clk,
  input  logic arst_n,
  input  logic mul_val,
  input  d_x_t mul_op,
  output logic mul_res_val,
  output x_w_t mul_res
);

  localparam int unsigned STAGES = `BLIMP_MUL_STAGES;

  logic [`BLIMP_XLEN-1:0] product;
  logic [STAGES-1:0]      val_q;
  x_w_t                   stage_q [STAGES];

  // Low word of the product only
  assign product = mul_op.op1 * mul_op.op2;

  //--------------------
  // Valid chain
  //--------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      val_q <= '0;
    end else begin
      val_q <= {val_q[STAGES-2:0], mul_val};
    end
  end

  //--------------------
  // Data stages
  //--------------------

  always_ff @(posedge clk) begin
    // First stage forms the product
    if (mul_val) begin
      stage_q[0] <= '{pc: mul_op.pc, seq: mul_op.seq, waddr: mul_op.waddr,
                      wen: mul_op.wen, data: product};
    end
    // Later stages only move data along
    for (int i = 1; i < STAGES; i++) begin
      if (val_q[i-1]) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign mul_res_val = val_q[STAGES-1];
  assign mul_res     = stage_q[STAGES-1];

endmodule

//--- hw/writeback_commit_unit.sv
//--------------------
// Writeback and commit unit
// Completes results as they arrive, commits them in sequence order
//--------------------

`include "blimp_params.svh"

module writeback_commit_unit import blimp_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      alu_res_val,
  input  x_w_t      alu_res,
  input  logic      mul_res_val,
  input  x_w_t      mul_res,
  output complete_t complete,
  output commit_t   commit
);

  localparam int unsigned DEPTH = 1 << `BLIMP_SEQ_BITS;

  logic                       res_val;
  x_w_t                       sel;
  x_w_t                       rob_q [DEPTH];
  logic [DEPTH-1:0]           done_q;
  logic [`BLIMP_SEQ_BITS-1:0] head_q;
  logic                       head_done;
  logic                       bypass;
  logic                       head_ready;
  x_w_t                       head_ent;
  logic [DEPTH-1:0]           done_set;
  logic [DEPTH-1:0]           done_clr;
  logic                       commit_val_q;
  x_w_t                       commit_ent_q;

  //--------------------
  // Completion
  //--------------------

  // Decode keeps the two pipes from finishing together
  assign res_val = alu_res_val || mul_res_val;
  assign sel     = alu_res_val ? alu_res : mul_res;

  assign complete = '{waddr: sel.waddr, wdata: sel.data, wen: sel.wen, val: res_val};

  //--------------------
  // Reorder buffer
  //--------------------

  assign head_done = done_q[head_q];
  // Head result arriving now commits without a stop in the buffer
  assign bypass     = res_val && (sel.seq == head_q);
  assign head_ready = head_done || bypass;
  assign head_ent   = head_done ? rob_q[head_q] : sel;

  assign done_set = (res_val && !bypass) ? (DEPTH'(1) << sel.seq) : '0;
  assign done_clr = head_done ? (DEPTH'(1) << head_q) : '0;

  always_ff @(posedge clk) begin
    if (res_val && !bypass) begin
      rob_q[sel.seq] <= sel;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done_q       <= '0;
      head_q       <= '0;
      commit_val_q <= 1'b0;
    end else begin
      done_q       <= (done_q & ~done_clr) | done_set;
      commit_val_q <= head_ready;
      if (head_ready) begin
        head_q <= head_q + 1'b1;
      end
    end
  end

  //--------------------
  // Commit
  //--------------------

  always_ff @(posedge clk) begin
    if (head_ready) begin
      commit_ent_q <= head_ent;
    end
  end

  assign commit = '{pc: commit_ent_q.pc, waddr: commit_ent_q.waddr,
                    wdata: commit_ent_q.data, wen: commit_ent_q.wen,
                    val: commit_val_q};

endmodule

//--- hw/blimp_top.sv
//--------------------
// Blimp core top
// Fetch, decode, two execute pipes and commit, with a trace output
//--------------------

module blimp_top import blimp_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  output logic      mem_req_val,
  output mem_req_t  mem_req,
  input  logic      mem_req_rdy,
  input  logic      mem_resp_val,
  input  mem_resp_t mem_resp,
  output logic      mem_resp_rdy,
  output commit_t   inst_trace
);

  //--------------------
  // Internal paths
  //--------------------

  logic      f_d_val;
  f_d_t      f_d;
  logic      f_d_rdy;
  logic      alu_val;
  d_x_t      alu_op;
  logic      mul_val;
  d_x_t      mul_op;
  logic      alu_res_val;
  x_w_t      alu_res;
  logic      mul_res_val;
  x_w_t      mul_res;
  complete_t complete;
  commit_t   commit;

  // Commit stream doubles as the trace
  assign inst_trace = commit;

  //--------------------
  // Units
  //--------------------

  fetch_unit u_fetch (
    .clk          (clk),
    .arst_n       (arst_n),
    .mem_req_val  (mem_req_val),
    .mem_req      (mem_req),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp_val (mem_resp_val),
    .mem_resp     (mem_resp),
    .mem_resp_rdy (mem_resp_rdy),
    .f_d_val      (f_d_val),
    .f_d          (f_d),
    .f_d_rdy      (f_d_rdy),
    .commit       (commit)
  );

  decode_issue_unit u_decode (
    .clk      (clk),
    .arst_n   (arst_n),
    .f_d_val  (f_d_val),
    .f_d      (f_d),
    .f_d_rdy  (f_d_rdy),
    .alu_val  (alu_val),
    .alu_op   (alu_op),
    .mul_val  (mul_val),
    .mul_op   (mul_op),
    .complete (complete)
  );

  alu_unit u_alu (
    .clk         (clk),
    .arst_n      (arst_n),
    .alu_val     (alu_val),
    .alu_op      (alu_op),
    .alu_res_val (alu_res_val),
    .alu_res     (alu_res)
  );

  pipelined_multiplier u_mul (
    .clk         (clk),
    .arst_n      (arst_n),
    .mul_val     (mul_val),
    .mul_op      (mul_op),
    .mul_res_val (mul_res_val),
    .mul_res     (mul_res)
  );

  writeback_commit_unit u_wb (
    .clk         (clk),
    .arst_n      (arst_n),
    .alu_res_val (alu_res_val),
    .alu_res     (alu_res),
    .mul_res_val (mul_res_val),
    .mul_res     (mul_res),
    .complete    (complete),
    .commit      (commit)
  );

endmodule

//--- tb/inst_mem_model.sv
//--------------------
// Instruction memory model
// Program array behind a val/rdy port with a random response delay
//--------------------

module inst_mem_model import blimp_pkg::*; #(
  parameter int unsigned DEPTH     = 64,
  parameter int unsigned MAX_DELAY = 3
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [31:0] prog [DEPTH],
  input  int unsigned prog_len,
  input  logic        hold_rdy,
  input  logic        mem_req_val,
  input  mem_req_t    mem_req,
  output logic        mem_req_rdy,
  output logic        mem_resp_val,
  output mem_resp_t   mem_resp,
  input  logic        mem_resp_rdy
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned AW = $clog2(DEPTH);

  logic        busy_q;
  int unsigned wait_q;
  mem_resp_t   resp_q;
  logic        in_range;

  // Words past the program are never granted, so fetch stops there
  assign in_range = (mem_req.addr[31:2] < prog_len);

  // Outputs settle shortly after the clock edge
  assign #1 mem_req_rdy  = !busy_q && !hold_rdy && in_range;
  assign #1 mem_resp_val = busy_q && (wait_q == 0);
  assign #1 mem_resp     = resp_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q <= 1'b0;
      wait_q <= 0;
      resp_q <= '0;
    end else if (!busy_q) begin
      // Latch word and tag, then wait 0 to MAX_DELAY cycles
      if (mem_req_val && mem_req_rdy) begin
        busy_q <= 1'b1;
        wait_q <= $urandom_range(MAX_DELAY, 0);
        resp_q <= '{data: prog[mem_req.addr[AW+1:2]], opaque: mem_req.opaque};
      end
    end else if (wait_q != 0) begin
      wait_q <= wait_q - 1;
    end else if (mem_resp_rdy) begin
      busy_q <= 1'b0;
    end
  end

endmodule

//--- tb/blimp_tb.sv
//--------------------
// Blimp core testbench
// Directed programs, trace checked against an in-order register model
//--------------------

`include "blimp_params.svh"

module blimp_tb import blimp_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned PROG_DEPTH   = 64;
  localparam int unsigned RESET_CYCLES = 8;
  localparam int unsigned HOLD_CYCLES  = 20;
  localparam int unsigned TEST_CYCLES  = 200;
  localparam int unsigned TAIL_CYCLES  = 10;
  localparam int unsigned N_TESTS      = 6;
  // Every test at its own limit, plus reset, tail, the stalled start and some slack
  localparam int unsigned MAX_CYCLES   =
    N_TESTS * (TEST_CYCLES + RESET_CYCLES + TAIL_CYCLES + 4) + HOLD_CYCLES;
  localparam logic [31:0] NOP_WORD     = 32'h0000_100f;

  logic        clk;
  logic        arst_n;
  logic        hold_rdy;
  logic [31:0] prog [PROG_DEPTH];
  int unsigned prog_len;
  int unsigned cycle_count;
  logic        mem_req_val;
  mem_req_t    mem_req;
  logic        mem_req_rdy;
  logic        mem_resp_val;
  mem_resp_t   mem_resp;
  logic        mem_resp_rdy;
  commit_t     inst_trace;

  // Staged program and golden results per instruction
  logic [31:0]            prog_buf  [PROG_DEPTH];
  logic [`BLIMP_XLEN-1:0] exp_wdata [PROG_DEPTH];
  logic [4:0]             exp_waddr [PROG_DEPTH];
  logic                   exp_wen   [PROG_DEPTH];

  blimp_top dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .mem_req_val  (mem_req_val),
    .mem_req      (mem_req),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp_val (mem_resp_val),
    .mem_resp     (mem_resp),
    .mem_resp_rdy (mem_resp_rdy),
    .inst_trace   (inst_trace)
  );

  inst_mem_model #(.DEPTH(PROG_DEPTH), .MAX_DELAY(3)) imem (
    .clk          (clk),
    .arst_n       (arst_n),
    .prog         (prog),
    .prog_len     (prog_len),
    .hold_rdy     (hold_rdy),
    .mem_req_val  (mem_req_val),
    .mem_req      (mem_req),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp_val (mem_resp_val),
    .mem_resp     (mem_resp),
    .mem_resp_rdy (mem_resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //--------------------
  // Failure and checks
  //--------------------

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      stop_with_failure("Trace or port value mismatch");
    end
  endtask

  // Run-wide watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      stop_with_failure("Timeout: the run went past its cycle limit");
    end
  end

  //--------------------
  // Instruction encoding
  //--------------------

  // R-type, funct7 0 is add and 1 is mul
  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] encode_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] encode_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  // Unused words, an unknown opcode tagged with the index
  function automatic logic [31:0] fill_word(input int unsigned idx);
    return (32'(idx) << 7) | 32'h7f;
  endfunction

  //--------------------
  // Golden model
  //--------------------

  // Runs the program in order, one result per instruction
  task automatic build_expected(input int unsigned n);
    logic [31:0] regs [32];
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] result;
    logic        writes;
    logic [4:0]  rd;
    int          i;
    for (i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (i = 0; i < int'(n); i++) begin
      inst   = prog[i];
      rd     = inst[11:7];
      a      = regs[inst[19:15]];
      b      = regs[inst[24:20]];
      writes = 1'b1;
      result = '0;
      if (inst[6:0] == 7'h33 && inst[14:12] == 3'd0 && inst[31:25] == 7'h00) begin
        result = a + b;
      end else if (inst[6:0] == 7'h33 && inst[14:12] == 3'd0 && inst[31:25] == 7'h01) begin
        // Low word of the product
        result = a * b;
      end else if (inst[6:0] == 7'h13 && inst[14:12] == 3'd0) begin
        result = a + {{20{inst[31]}}, inst[31:20]};
      end else if (inst[6:0] == 7'h37) begin
        result = {inst[31:12], 12'h000};
      end else begin
        writes = 1'b0;
      end
      exp_wen[i]   = writes && (rd != 5'd0);
      exp_waddr[i] = rd;
      exp_wdata[i] = result;
      if (exp_wen[i]) begin
        regs[rd] = result;
      end
    end
  endtask

  //--------------------
  // Sequencing
  //--------------------

  // Reset, load the staged program and check the quiet outputs meanwhile
  task automatic apply_reset(input int unsigned n);
    int i;
    @(posedge clk);
    #1;
    arst_n = 1'b0;
    for (i = 0; i < PROG_DEPTH; i++) begin
      prog[i] = (i < int'(n)) ? prog_buf[i] : fill_word(i);
    end
    prog_len = n;
    build_expected(n);
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check("inst_trace.val", 32'(inst_trace.val), 32'd0);
    end
    @(posedge clk);
    #1;
    arst_n = 1'b1;
  endtask

  task automatic collect_trace(input int unsigned n);
    int unsigned idx;
    int unsigned req_idx;
    int unsigned waited;
    idx     = 0;
    req_idx = 0;
    waited  = 0;
    while (idx < n) begin
      @(negedge clk);
      waited++;
      if (waited > TEST_CYCLES) begin
        stop_with_failure($sformatf("Timeout: only %0d of %0d trace records in %0d cycles",
                                    idx, n, TEST_CYCLES));
      end
      check("mem_resp_rdy", 32'(mem_resp_rdy), 32'd1);
      // Requests go out in pc order from zero
      if (mem_req_val && mem_req_rdy) begin
        check("mem_req.addr", mem_req.addr, 32'(req_idx * 4));
        req_idx++;
      end
      if (inst_trace.val) begin
        // Strict program order, pc is four times the index
        check("inst_trace.pc", inst_trace.pc, 32'(idx * 4));
        check("inst_trace.wen", 32'(inst_trace.wen), 32'(exp_wen[idx]));
        if (exp_wen[idx]) begin
          check("inst_trace.waddr", 32'(inst_trace.waddr), 32'(exp_waddr[idx]));
          check("inst_trace.wdata", inst_trace.wdata, exp_wdata[idx]);
        end
        idx++;
      end
    end
    // No record past the end of the program
    repeat (TAIL_CYCLES) begin
      @(negedge clk);
      check("inst_trace.val", 32'(inst_trace.val), 32'd0);
    end
  endtask

  task automatic run_program(input int unsigned n);
    apply_reset(n);
    collect_trace(n);
  endtask

  //--------------------
  // Directed tests
  //--------------------

  task automatic reset_with_stalled_memory();
    $display("Test: reset with memory stalled");
    prog_buf[0] = encode_addi(5'd1, 5'd0, 12'd5);
    prog_buf[1] = encode_lui(5'd2, 20'habcde);
    hold_rdy = 1'b1;
    apply_reset(2);
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      check("inst_trace.val", 32'(inst_trace.val), 32'd0);
      check("mem_req_val", 32'(mem_req_val), 32'd0);
      check("mem_resp_rdy", 32'(mem_resp_rdy), 32'd1);
    end
    // Fetch starts once memory is ready
    @(posedge clk);
    #1;
    hold_rdy = 1'b0;
    collect_trace(2);
  endtask

  task automatic addi_lui_chain();
    $display("Test: addi and lui chain");
    prog_buf[0] = encode_lui(5'd1, 20'h12345);
    prog_buf[1] = encode_addi(5'd1, 5'd1, 12'h678);
    prog_buf[2] = encode_addi(5'd2, 5'd0, 12'hffb);
    prog_buf[3] = encode_lui(5'd3, 20'hfffff);
    prog_buf[4] = encode_addi(5'd3, 5'd3, 12'hfff);
    prog_buf[5] = encode_addi(5'd4, 5'd2, 12'd100);
    run_program(6);
  endtask

  task automatic raw_through_add();
    $display("Test: back-to-back RAW through add");
    prog_buf[0] = encode_addi(5'd1, 5'd0, 12'd7);
    prog_buf[1] = encode_addi(5'd2, 5'd0, 12'd9);
    prog_buf[2] = encode_r(7'h00, 5'd3, 5'd1, 5'd2);
    prog_buf[3] = encode_r(7'h00, 5'd4, 5'd3, 5'd3);
    prog_buf[4] = encode_r(7'h00, 5'd5, 5'd4, 5'd1);
    prog_buf[5] = encode_r(7'h00, 5'd6, 5'd5, 5'd5);
    prog_buf[6] = encode_r(7'h00, 5'd5, 5'd6, 5'd4);
    run_program(7);
  endtask

  task automatic mul_chain_mixed();
    $display("Test: mul chain with mixed operands");
    prog_buf[0] = encode_addi(5'd1, 5'd0, 12'hffd);
    prog_buf[1] = encode_lui(5'd2, 20'h00010);
    prog_buf[2] = encode_addi(5'd2, 5'd2, 12'd7);
    prog_buf[3] = encode_r(7'h01, 5'd3, 5'd1, 5'd2);
    prog_buf[4] = encode_r(7'h01, 5'd4, 5'd3, 5'd3);
    prog_buf[5] = encode_r(7'h01, 5'd5, 5'd4, 5'd1);
    prog_buf[6] = encode_lui(5'd6, 20'h80000);
    prog_buf[7] = encode_r(7'h01, 5'd7, 5'd6, 5'd1);
    prog_buf[8] = encode_r(7'h01, 5'd8, 5'd2, 5'd0);
    run_program(9);
  endtask

  task automatic out_of_order_commit();
    $display("Test: out-of-order completion, in-order commit");
    prog_buf[0] = encode_addi(5'd1, 5'd0, 12'd12);
    prog_buf[1] = encode_addi(5'd2, 5'd0, 12'd34);
    prog_buf[2] = encode_r(7'h01, 5'd3, 5'd1, 5'd2);
    // Independent of the mul, these finish first
    prog_buf[3] = encode_addi(5'd4, 5'd0, 12'd1);
    prog_buf[4] = encode_addi(5'd5, 5'd0, 12'd2);
    prog_buf[5] = encode_addi(5'd6, 5'd0, 12'd3);
    prog_buf[6] = encode_r(7'h00, 5'd7, 5'd4, 5'd5);
    prog_buf[7] = encode_addi(5'd8, 5'd6, 12'd4);
    prog_buf[8] = encode_r(7'h00, 5'd9, 5'd3, 5'd7);
    run_program(9);
  endtask

  // Sources only from registers this program already wrote
  function automatic logic [4:0] pick_source(input logic [15:0] known);
    logic [4:0] r;
    r = 5'($urandom_range(15, 0));
    return known[r[3:0]] ? r : 5'd0;
  endfunction

  task automatic random_mixed_program();
    logic [15:0] known;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    int unsigned kind;
    int          i;
    $display("Test: random mixed program of 40");
    known = 16'h0001;
    for (i = 0; i < 40; i++) begin
      kind = $urandom_range(9, 0);
      rd   = 5'($urandom_range(15, 1));
      rs1  = pick_source(known);
      rs2  = pick_source(known);
      case (kind)
        0, 1:    prog_buf[i] = encode_r(7'h01, rd, rs1, rs2);
        2, 3:    prog_buf[i] = encode_r(7'h00, rd, rs1, rs2);
        4, 5:    prog_buf[i] = encode_addi(rd, rs1, 12'($urandom));
        6, 7:    prog_buf[i] = encode_lui(rd, 20'($urandom));
        8:       prog_buf[i] = NOP_WORD;
        // Write to x0 is dropped
        default: prog_buf[i] = encode_addi(5'd0, rs1, 12'($urandom));
      endcase
      if (kind < 8) begin
        known[rd[3:0]] = 1'b1;
      end
    end
    run_program(40);
  endtask

  //--------------------
  // Main sequence
  //--------------------

  initial begin
    void'($urandom(52));
    arst_n      = 1'b0;
    hold_rdy    = 1'b0;
    prog_len    = 0;
    cycle_count = 0;
    for (int i = 0; i < PROG_DEPTH; i++) begin
      prog[i] = fill_word(i);
    end
    reset_with_stalled_memory();
    addi_lui_chain();
    raw_through_add();
    mul_chain_mixed();
    out_of_order_commit();
    random_mixed_program();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- project.f
+incdir+hw
hw/blimp_pkg.sv
hw/fetch_unit.sv
hw/decode_issue_unit.sv
hw/alu_unit.sv
hw/pipelined_multiplier.sv
hw/writeback_commit_unit.sv
hw/blimp_top.sv
tb/inst_mem_model.sv
tb/blimp_tb.sv

//--- Makefile
# Verilator build and run of the blimp core testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       ?= blimp_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# The simulator exits non-zero when the testbench stops with $$fatal
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
